/* rtl/noc_pkg.sv */
// flit field widths, vector typedefs, flit field positions, opcodes and router port indices
package noc_pkg;

  localparam int cord_width = 2;
  localparam int addr_width = 4;
  localparam int word_width = 16;
  localparam int tag_width  = 4;
  localparam int flit_width = 3*cord_width + 1 + tag_width + addr_width + word_width;

  typedef logic [cord_width-1:0] cord_t;
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [word_width-1:0] word_t;
  typedef logic [tag_width-1:0]  tag_t;
  typedef logic [flit_width-1:0] flit_t;

  // lowest bit of each flit field, data at the bottom and dest_y on top
  localparam int data_lsb   = 0;
  localparam int addr_lsb   = data_lsb + word_width;
  localparam int tag_lsb    = addr_lsb + addr_width;
  localparam int op_bit     = tag_lsb + tag_width;
  localparam int src_x_lsb  = op_bit + 1;
  localparam int dest_x_lsb = src_x_lsb + cord_width;
  localparam int dest_y_lsb = dest_x_lsb + cord_width;

  localparam logic op_read  = 1'b0;
  localparam logic op_write = 1'b1;

  // router port indices
  localparam int dir_p = 0; // local, to the memory node
  localparam int dir_w = 1;
  localparam int dir_e = 2;
  localparam int dir_n = 3; // row 0 side
  localparam int dir_s = 4;
  localparam int num_dirs = 5;

endpackage

/* rtl/mesh_router.sv */
// five-port XY mesh router with one-entry input buffers and round-robin output arbiters
`timescale 1ns/1ns

module mesh_router
  #(parameter noc_pkg::cord_t x_cord_p = '0
    , parameter noc_pkg::cord_t y_cord_p = '0
    )
  (input logic                                       core_clk_i
   , input logic                                     reset_i

   , input logic [noc_pkg::num_dirs-1:0]             link_v_i
   , input noc_pkg::flit_t [noc_pkg::num_dirs-1:0]   link_data_i
   , output logic [noc_pkg::num_dirs-1:0]            link_ready_and_o

   , output logic [noc_pkg::num_dirs-1:0]            link_v_o
   , output noc_pkg::flit_t [noc_pkg::num_dirs-1:0]  link_data_o
   , input logic [noc_pkg::num_dirs-1:0]             link_ready_and_i
   );

  localparam int dirs_lp = noc_pkg::num_dirs;
  localparam int dir_width_lp = $clog2(dirs_lp);

  typedef logic [dir_width_lp-1:0] dir_idx_t;

  logic [dirs_lp-1:0]           buf_v_r;
  noc_pkg::flit_t [dirs_lp-1:0] buf_data_r;
  dir_idx_t [dirs_lp-1:0]       want_dir;   // routed output of each buffered flit
  logic [dirs_lp-1:0]           buf_sent;

  dir_idx_t [dirs_lp-1:0]       rr_ptr_r;   // per output, highest priority input
  dir_idx_t [dirs_lp-1:0]       gnt_idx;
  logic [dirs_lp-1:0]           gnt_v;

  // a buffer only takes a flit when it is empty
  assign link_ready_and_o = ~buf_v_r;

  for (genvar i = 0; i < dirs_lp; i++)
    begin : route
      noc_pkg::cord_t dest_x;
      noc_pkg::cord_t dest_y;

      assign dest_x = buf_data_r[i][noc_pkg::dest_x_lsb +: noc_pkg::cord_width];
      assign dest_y = buf_data_r[i][noc_pkg::dest_y_lsb +: noc_pkg::cord_width];

      // x first, then y, larger y lies further south
      assign want_dir[i] = (dest_x > x_cord_p) ? dir_idx_t'(noc_pkg::dir_e)
                         : (dest_x < x_cord_p) ? dir_idx_t'(noc_pkg::dir_w)
                         : (dest_y > y_cord_p) ? dir_idx_t'(noc_pkg::dir_s)
                         : (dest_y < y_cord_p) ? dir_idx_t'(noc_pkg::dir_n)
                         : dir_idx_t'(noc_pkg::dir_p);
    end

  // round-robin search from the pointer, the nearest requester wins
  always_comb
    begin
      int cand;
      for (int o = 0; o < dirs_lp; o++)
        begin
          gnt_v[o]   = 1'b0;
          gnt_idx[o] = rr_ptr_r[o];
          for (int k = dirs_lp-1; k >= 0; k--)
            begin
              cand = int'(rr_ptr_r[o]) + k;
              if (cand >= dirs_lp)
                cand = cand - dirs_lp;
              if (buf_v_r[cand] && (want_dir[cand] == dir_idx_t'(o)))
                begin
                  gnt_v[o]   = 1'b1;
                  gnt_idx[o] = dir_idx_t'(cand);
                end
            end
        end
    end

  always_comb
    begin
      buf_sent = '0;
      for (int o = 0; o < dirs_lp; o++)
        begin
          if (gnt_v[o] && link_ready_and_i[o])
            buf_sent[gnt_idx[o]] = 1'b1;
        end
    end

  assign link_v_o = gnt_v;

  for (genvar o = 0; o < dirs_lp; o++)
    begin : out
      assign link_data_o[o] = buf_data_r[gnt_idx[o]];
    end

  always_ff @(posedge core_clk_i)
    begin
      for (int i = 0; i < dirs_lp; i++)
        begin
          if (reset_i)
            buf_v_r[i] <= 1'b0;
          else if (!buf_v_r[i])
            buf_v_r[i] <= link_v_i[i];
          else if (buf_sent[i])
            buf_v_r[i] <= 1'b0;

          if (!buf_v_r[i] && link_v_i[i])
            buf_data_r[i] <= link_data_i[i];
        end
    end

  // pointer parks on a stalled grant so the output holds steady
  always_ff @(posedge core_clk_i)
    begin
      for (int o = 0; o < dirs_lp; o++)
        begin
          if (reset_i)
            rr_ptr_r[o] <= '0;
          else if (gnt_v[o] && !link_ready_and_i[o])
            rr_ptr_r[o] <= gnt_idx[o];
          else if (gnt_v[o])
            rr_ptr_r[o] <= (int'(gnt_idx[o]) == dirs_lp-1) ? '0 : gnt_idx[o] + 1'b1;
        end
    end

endmodule

/* rtl/tile_mem_node.sv */
// tile memory node that executes one command flit at a time and returns a response flit
`timescale 1ns/1ns

module tile_mem_node
  (input logic              core_clk_i
   , input logic            reset_i

   , input logic            cmd_v_i
   , input noc_pkg::flit_t  cmd_data_i
   , output logic           cmd_ready_and_o

   , output logic           resp_v_o
   , output noc_pkg::flit_t resp_data_o
   , input logic            resp_ready_and_i
   );

  localparam int mem_words_lp = 2**noc_pkg::addr_width;

  typedef enum logic {e_idle, e_respond} state_e;

  state_e         state_r;
  noc_pkg::word_t mem_r [mem_words_lp];
  noc_pkg::flit_t resp_r;
  noc_pkg::flit_t resp_n;
  noc_pkg::addr_t cmd_addr;
  logic           cmd_write;
  logic           cmd_fire;

  assign cmd_ready_and_o = (state_r == e_idle);
  assign cmd_fire  = cmd_v_i & cmd_ready_and_o;
  assign cmd_addr  = cmd_data_i[noc_pkg::addr_lsb +: noc_pkg::addr_width];
  assign cmd_write = (cmd_data_i[noc_pkg::op_bit] == noc_pkg::op_write);

  // op, tag and addr ride along unchanged, a write echoes its own data
  always_comb
    begin
      resp_n = cmd_data_i;
      resp_n[noc_pkg::dest_y_lsb +: noc_pkg::cord_width] = '0;
      resp_n[noc_pkg::dest_x_lsb +: noc_pkg::cord_width] =
        cmd_data_i[noc_pkg::src_x_lsb +: noc_pkg::cord_width];
      if (!cmd_write)
        resp_n[noc_pkg::data_lsb +: noc_pkg::word_width] = mem_r[cmd_addr];
    end

  always_ff @(posedge core_clk_i)
    begin
      if (reset_i)
        begin
          state_r <= e_idle;
          for (int a = 0; a < mem_words_lp; a++)
            mem_r[a] <= '0;
        end
      else
        begin
          case (state_r)
            e_idle:
              begin
                if (cmd_fire)
                  state_r <= e_respond;
                if (cmd_fire && cmd_write)
                  mem_r[cmd_addr] <= cmd_data_i[noc_pkg::data_lsb +: noc_pkg::word_width];
              end
            default:
              begin
                if (resp_ready_and_i)
                  state_r <= e_idle; // response taken
              end
          endcase
        end

      if (cmd_fire)
        resp_r <= resp_n;
    end

  assign resp_v_o    = (state_r == e_respond);
  assign resp_data_o = resp_r;

endmodule

/* rtl/core_complex.sv */
// core complex top with a grid of command and response routers and a memory node per tile
`timescale 1ns/1ns

module core_complex
  #(parameter int x_dim_p = 2
    , parameter int y_dim_p = 2
    )
  (input logic                                  core_clk_i
   , input logic                                reset_i

   , input logic [x_dim_p-1:0]                  cmd_v_i
   , input noc_pkg::flit_t [x_dim_p-1:0]        cmd_data_i
   , output logic [x_dim_p-1:0]                 cmd_ready_and_o

   , output logic [x_dim_p-1:0]                 resp_v_o
   , output noc_pkg::flit_t [x_dim_p-1:0]       resp_data_o
   , input logic [x_dim_p-1:0]                  resp_ready_and_i
   );

  localparam int dirs_lp     = noc_pkg::num_dirs;
  localparam int cmd_net_lp  = 0;
  localparam int resp_net_lp = 1;

  // indexed [network][row][column][port]
  logic [1:0][y_dim_p-1:0][x_dim_p-1:0][dirs_lp-1:0]           v_li;
  logic [1:0][y_dim_p-1:0][x_dim_p-1:0][dirs_lp-1:0]           v_lo;
  logic [1:0][y_dim_p-1:0][x_dim_p-1:0][dirs_lp-1:0]           ready_li;
  logic [1:0][y_dim_p-1:0][x_dim_p-1:0][dirs_lp-1:0]           ready_lo;
  noc_pkg::flit_t [1:0][y_dim_p-1:0][x_dim_p-1:0][dirs_lp-1:0] data_li;
  noc_pkg::flit_t [1:0][y_dim_p-1:0][x_dim_p-1:0][dirs_lp-1:0] data_lo;

  for (genvar y = 0; y < y_dim_p; y++)
    begin : row
      for (genvar x = 0; x < x_dim_p; x++)
        begin : col
          mesh_router
           #(.x_cord_p(noc_pkg::cord_t'(x)), .y_cord_p(noc_pkg::cord_t'(1 + y)))
           cmd_router
            (.core_clk_i(core_clk_i)
             ,.reset_i(reset_i)
             ,.link_v_i(v_li[cmd_net_lp][y][x])
             ,.link_data_i(data_li[cmd_net_lp][y][x])
             ,.link_ready_and_o(ready_lo[cmd_net_lp][y][x])
             ,.link_v_o(v_lo[cmd_net_lp][y][x])
             ,.link_data_o(data_lo[cmd_net_lp][y][x])
             ,.link_ready_and_i(ready_li[cmd_net_lp][y][x])
             );

          mesh_router
           #(.x_cord_p(noc_pkg::cord_t'(x)), .y_cord_p(noc_pkg::cord_t'(1 + y)))
           resp_router
            (.core_clk_i(core_clk_i)
             ,.reset_i(reset_i)
             ,.link_v_i(v_li[resp_net_lp][y][x])
             ,.link_data_i(data_li[resp_net_lp][y][x])
             ,.link_ready_and_o(ready_lo[resp_net_lp][y][x])
             ,.link_v_o(v_lo[resp_net_lp][y][x])
             ,.link_data_o(data_lo[resp_net_lp][y][x])
             ,.link_ready_and_i(ready_li[resp_net_lp][y][x])
             );

          tile_mem_node
           mem_node
            (.core_clk_i(core_clk_i)
             ,.reset_i(reset_i)
             ,.cmd_v_i(v_lo[cmd_net_lp][y][x][noc_pkg::dir_p])
             ,.cmd_data_i(data_lo[cmd_net_lp][y][x][noc_pkg::dir_p])
             ,.cmd_ready_and_o(ready_li[cmd_net_lp][y][x][noc_pkg::dir_p])
             ,.resp_v_o(v_li[resp_net_lp][y][x][noc_pkg::dir_p])
             ,.resp_data_o(data_li[resp_net_lp][y][x][noc_pkg::dir_p])
             ,.resp_ready_and_i(ready_lo[resp_net_lp][y][x][noc_pkg::dir_p])
             );

          // nothing enters the command net locally, responses never end at a tile
          assign v_li[cmd_net_lp][y][x][noc_pkg::dir_p]        = 1'b0;
          assign data_li[cmd_net_lp][y][x][noc_pkg::dir_p]     = '0;
          assign ready_li[resp_net_lp][y][x][noc_pkg::dir_p]   = 1'b1;

          for (genvar n = 0; n < 2; n++)
            begin : net
              if (x == 0)
                begin : w_edge
                  assign v_li[n][y][x][noc_pkg::dir_w]     = 1'b0;
                  assign data_li[n][y][x][noc_pkg::dir_w]  = '0;
                  assign ready_li[n][y][x][noc_pkg::dir_w] = 1'b1;
                end
              else
                begin : w_link
                  assign v_li[n][y][x][noc_pkg::dir_w]     = v_lo[n][y][x-1][noc_pkg::dir_e];
                  assign data_li[n][y][x][noc_pkg::dir_w]  = data_lo[n][y][x-1][noc_pkg::dir_e];
                  assign ready_li[n][y][x][noc_pkg::dir_w] = ready_lo[n][y][x-1][noc_pkg::dir_e];
                end

              if (x == x_dim_p-1)
                begin : e_edge
                  assign v_li[n][y][x][noc_pkg::dir_e]     = 1'b0;
                  assign data_li[n][y][x][noc_pkg::dir_e]  = '0;
                  assign ready_li[n][y][x][noc_pkg::dir_e] = 1'b1;
                end
              else
                begin : e_link
                  assign v_li[n][y][x][noc_pkg::dir_e]     = v_lo[n][y][x+1][noc_pkg::dir_w];
                  assign data_li[n][y][x][noc_pkg::dir_e]  = data_lo[n][y][x+1][noc_pkg::dir_w];
                  assign ready_li[n][y][x][noc_pkg::dir_e] = ready_lo[n][y][x+1][noc_pkg::dir_w];
                end

              if (y == y_dim_p-1)
                begin : s_edge
                  assign v_li[n][y][x][noc_pkg::dir_s]     = 1'b0;
                  assign data_li[n][y][x][noc_pkg::dir_s]  = '0;
                  assign ready_li[n][y][x][noc_pkg::dir_s] = 1'b1;
                end
              else
                begin : s_link
                  assign v_li[n][y][x][noc_pkg::dir_s]     = v_lo[n][y+1][x][noc_pkg::dir_n];
                  assign data_li[n][y][x][noc_pkg::dir_s]  = data_lo[n][y+1][x][noc_pkg::dir_n];
                  assign ready_li[n][y][x][noc_pkg::dir_s] = ready_lo[n][y+1][x][noc_pkg::dir_n];
                end

              if (y != 0)
                begin : n_link
                  assign v_li[n][y][x][noc_pkg::dir_n]     = v_lo[n][y-1][x][noc_pkg::dir_s];
                  assign data_li[n][y][x][noc_pkg::dir_n]  = data_lo[n][y-1][x][noc_pkg::dir_s];
                  assign ready_li[n][y][x][noc_pkg::dir_n] = ready_lo[n][y-1][x][noc_pkg::dir_s];
                end
              else if (n == cmd_net_lp)
                begin : n_cmd_edge
                  assign v_li[n][y][x][noc_pkg::dir_n]     = cmd_v_i[x];
                  assign data_li[n][y][x][noc_pkg::dir_n]  = cmd_data_i[x];
                  assign cmd_ready_and_o[x]                = ready_lo[n][y][x][noc_pkg::dir_n];
                  assign ready_li[n][y][x][noc_pkg::dir_n] = 1'b1; // commands never head north
                end
              else
                begin : n_resp_edge
                  assign v_li[n][y][x][noc_pkg::dir_n]     = 1'b0;
                  assign data_li[n][y][x][noc_pkg::dir_n]  = '0;
                  assign resp_v_o[x]                       = v_lo[n][y][x][noc_pkg::dir_n];
                  assign resp_data_o[x]                    = data_lo[n][y][x][noc_pkg::dir_n];
                  assign ready_li[n][y][x][noc_pkg::dir_n] = resp_ready_and_i[x];
                end
            end
        end
    end

endmodule

/* tb/core_complex_chk.sv */
// concurrent assertions on the core complex response ports, bound into the top level
`timescale 1ns/1ns

module core_complex_chk
  #(parameter int x_dim_p = 2
    )
  (input logic                           core_clk_i
   , input logic                         reset_i
   , input logic [x_dim_p-1:0]           resp_v_o
   , input noc_pkg::flit_t [x_dim_p-1:0] resp_data_o
   , input logic [x_dim_p-1:0]           resp_ready_and_i
   );

  for (genvar c = 0; c < x_dim_p; c++)
    begin : col
      // a refused response keeps valid and data
      hold_a: assert property (@(posedge core_clk_i) disable iff (reset_i)
          (resp_v_o[c] && !resp_ready_and_i[c]) |=> (resp_v_o[c] && $stable(resp_data_o[c])))
        else $error("column %0d response dropped or changed before it was taken", c);

      reset_a: assert property (@(posedge core_clk_i) reset_i |=> !resp_v_o[c])
        else $error("column %0d response valid right after reset", c);

      // responses leave only on the column named by dest_x
      route_a: assert property (@(posedge core_clk_i) disable iff (reset_i)
          resp_v_o[c] |->
            (resp_data_o[c][noc_pkg::dest_x_lsb +: noc_pkg::cord_width] == noc_pkg::cord_t'(c)))
        else $error("column %0d carries a response for another column", c);
    end

endmodule

/* tb/core_complex_tb.sv */
// core complex testbench with reset, stimulus table, reference memory, random traffic and checks
`timescale 1ns/1ns

module core_complex_tb;

  localparam int x_dim_lp = 2;
  localparam int y_dim_lp = 2;
  localparam int tags_lp = 2**noc_pkg::tag_width;
  localparam int rows_lp = 23;
  localparam int rand_cmds_lp = 40;
  localparam int reset_cycles_lp = 10;
  localparam int cycle_limit_lp = 64 * (rows_lp + rand_cmds_lp) + reset_cycles_lp;
  localparam logic rd_lp = noc_pkg::op_read;
  localparam logic wr_lp = noc_pkg::op_write;

  typedef struct packed {
    logic           col;
    noc_pkg::cord_t dx;
    noc_pkg::cord_t dy;
    logic           op;
    noc_pkg::addr_t addr;
    noc_pkg::word_t data;
    logic [3:0]     test;
  } row_t;

  logic                          core_clk;
  logic                          reset;
  logic [x_dim_lp-1:0]           cmd_v;
  noc_pkg::flit_t [x_dim_lp-1:0] cmd_data;
  logic [x_dim_lp-1:0]           cmd_ready_and;
  logic [x_dim_lp-1:0]           resp_v;
  noc_pkg::flit_t [x_dim_lp-1:0] resp_data;
  logic [x_dim_lp-1:0]           resp_ready_and;

  row_t           stim_tab [rows_lp];
  noc_pkg::word_t ref_mem [x_dim_lp*y_dim_lp][2**noc_pkg::addr_width];
  noc_pkg::flit_t exp_flit [x_dim_lp][tags_lp];
  logic           exp_v [x_dim_lp][tags_lp];   // command issued, response still due
  noc_pkg::flit_t cmd_q [x_dim_lp][$];
  noc_pkg::tag_t  next_tag [x_dim_lp];
  int             stall_run [x_dim_lp];        // cycles a command has waited for ready
  logic [x_dim_lp-1:0] hold_resp;
  logic [x_dim_lp-1:0] cmd_sent;
  logic [31:0]    lcg_state;
  int cycles = 0;
  int errors = 0;
  int test_errors = 0;
  int test_cmds = 0;
  int test_resps = 0;
  int total_cmds = 0;
  int total_resps = 0;

  core_complex #(.x_dim_p(x_dim_lp), .y_dim_p(y_dim_lp)) dut0
    (.core_clk_i(core_clk), .reset_i(reset)
     ,.cmd_v_i(cmd_v), .cmd_data_i(cmd_data), .cmd_ready_and_o(cmd_ready_and)
     ,.resp_v_o(resp_v), .resp_data_o(resp_data), .resp_ready_and_i(resp_ready_and)
     );

  bind core_complex core_complex_chk #(.x_dim_p(x_dim_p)) chk0
    (.core_clk_i(core_clk_i), .reset_i(reset_i), .resp_v_o(resp_v_o)
     ,.resp_data_o(resp_data_o), .resp_ready_and_i(resp_ready_and_i));

  always #20 core_clk = ~core_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic noc_pkg::flit_t make_flit(input logic col, input noc_pkg::cord_t dx,
    input noc_pkg::cord_t dy, input logic op, input noc_pkg::addr_t addr,
    input noc_pkg::word_t data);
    noc_pkg::flit_t f;
    f = '0;
    f[noc_pkg::dest_y_lsb +: noc_pkg::cord_width] = dy;
    f[noc_pkg::dest_x_lsb +: noc_pkg::cord_width] = dx;
    f[noc_pkg::src_x_lsb +: noc_pkg::cord_width] = noc_pkg::cord_t'(col);
    f[noc_pkg::op_bit] = op;
    f[noc_pkg::addr_lsb +: noc_pkg::addr_width] = addr;
    f[noc_pkg::data_lsb +: noc_pkg::word_width] = data;
    return f;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int c = 0; c < x_dim_lp; c++)
      for (int t = 0; t < tags_lp; t++)
        n += int'(exp_v[c][t]);
    return n;
  endfunction

  function automatic int pending();
    int n;
    n = outstanding() + $countones(cmd_v);
    for (int c = 0; c < x_dim_lp; c++)
      n += cmd_q[c].size();
    return n;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp)
      begin
        $display("error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        errors++;
        test_errors++;
      end
  endtask

  // predicted response for a command that fires on the coming edge
  task automatic record_cmd(input int c, input noc_pkg::flit_t f);
    noc_pkg::flit_t e;
    noc_pkg::tag_t  tag;
    noc_pkg::addr_t a;
    int             tile;
    tag = f[noc_pkg::tag_lsb +: noc_pkg::tag_width];
    a = f[noc_pkg::addr_lsb +: noc_pkg::addr_width];
    tile = (int'(f[noc_pkg::dest_y_lsb +: noc_pkg::cord_width]) - 1) * x_dim_lp
           + int'(f[noc_pkg::dest_x_lsb +: noc_pkg::cord_width]);
    e = f;
    e[noc_pkg::dest_y_lsb +: noc_pkg::cord_width] = '0;
    e[noc_pkg::dest_x_lsb +: noc_pkg::cord_width] = noc_pkg::cord_t'(c);
    if (f[noc_pkg::op_bit] == wr_lp)
      ref_mem[tile][a] = f[noc_pkg::data_lsb +: noc_pkg::word_width];
    else
      e[noc_pkg::data_lsb +: noc_pkg::word_width] = ref_mem[tile][a];
    exp_flit[c][tag] = e;
    exp_v[c][tag] = 1'b1;
    test_cmds++;
    total_cmds++;
  endtask

  task automatic take_resp(input int c, input noc_pkg::flit_t f);
    noc_pkg::tag_t tag;
    tag = f[noc_pkg::tag_lsb +: noc_pkg::tag_width];
    check(32'(exp_v[c][tag]), 32'd1, $sformatf("column %0d response tag %0d unexpected", c, tag));
    if (exp_v[c][tag])
      check(32'(f), 32'(exp_flit[c][tag]), $sformatf("column %0d response for tag %0d", c, tag));
    exp_v[c][tag] = 1'b0;
    test_resps++;
    total_resps++;
  endtask

  // one clock: inputs change on the falling edge, handshakes fire on the next rising edge
  task automatic cycle();
    noc_pkg::flit_t f;
    @(negedge core_clk);
    for (int c = 0; c < x_dim_lp; c++)
      begin
        resp_ready_and[c] = ~hold_resp[c];
        if (resp_v[c] && resp_ready_and[c])
          take_resp(c, resp_data[c]);
        if (cmd_sent[c])
          begin
            cmd_v[c] = 1'b0;
            cmd_sent[c] = 1'b0;
          end
        if (!cmd_v[c] && cmd_q[c].size() > 0 && !exp_v[c][next_tag[c]])
          begin
            f = cmd_q[c][0];
            f[noc_pkg::tag_lsb +: noc_pkg::tag_width] = next_tag[c];
            cmd_data[c] = f;
            cmd_v[c] = 1'b1;
          end
        stall_run[c] = (cmd_v[c] && !cmd_ready_and[c]) ? stall_run[c] + 1 : 0;
        if (cmd_v[c] && cmd_ready_and[c])
          begin
            record_cmd(c, cmd_data[c]);
            void'(cmd_q[c].pop_front());
            next_tag[c] = next_tag[c] + 1'b1;
            cmd_sent[c] = 1'b1;
          end
      end
  endtask

  task automatic queue_rows(input int t);
    for (int r = 0; r < rows_lp; r++)
      begin
        if (int'(stim_tab[r].test) == t)
          cmd_q[stim_tab[r].col].push_back(make_flit(stim_tab[r].col, stim_tab[r].dx,
            stim_tab[r].dy, stim_tab[r].op, stim_tab[r].addr, stim_tab[r].data));
      end
  endtask

  task automatic finish_test(input int t);
    check(32'(test_resps), 32'(test_cmds), $sformatf("test %0d response count", t));
    $display("test %0d %s: %0d commands, %0d responses, %0d errors", t,
             (test_errors == 0) ? "ok" : "bad", test_cmds, test_resps, test_errors);
    test_errors = 0;
    test_cmds = 0;
    test_resps = 0;
  endtask

  always @(posedge core_clk)
    begin
      cycles = cycles + 1;
      if (cycles > cycle_limit_lp)
        begin
          $display("timeout: run still busy after %0d cycles, %0d commands unanswered",
                   cycle_limit_lp, outstanding());
          $display("CHECKS FAILED");
          $finish;
        end
    end

  initial
    begin
      logic           col;
      logic           op;
      noc_pkg::cord_t dx;
      noc_pkg::cord_t dy;
      noc_pkg::addr_t addr;
      core_clk = 1'b0;
      reset = 1'b1;
      cmd_v = '0;
      cmd_data = '0;
      resp_ready_and = '1;
      hold_resp = '0;
      cmd_sent = '0;
      lcg_state = 32'hf112_477c;
      for (int c = 0; c < x_dim_lp; c++)
        begin
          next_tag[c] = '0;
          stall_run[c] = 0;
          for (int t = 0; t < tags_lp; t++)
            exp_v[c][t] = 1'b0;
        end
      for (int i = 0; i < x_dim_lp*y_dim_lp; i++)
        for (int a = 0; a < 2**noc_pkg::addr_width; a++)
          ref_mem[i][a] = '0;
      // column, dest x, dest y, op, address, data, test
      stim_tab = '{
        '{1'b0, 2'd0, 2'd1, rd_lp, 4'd3, 16'h0000, 4'd1},
        '{1'b1, 2'd1, 2'd2, rd_lp, 4'd9, 16'h0000, 4'd1},
        '{1'b0, 2'd0, 2'd1, wr_lp, 4'd5, 16'h1234, 4'd2},
        '{1'b0, 2'd0, 2'd1, rd_lp, 4'd5, 16'h0000, 4'd2},
        '{1'b1, 2'd1, 2'd1, wr_lp, 4'd2, 16'hbeef, 4'd2},
        '{1'b1, 2'd1, 2'd1, rd_lp, 4'd2, 16'h0000, 4'd2},
        '{1'b0, 2'd1, 2'd1, wr_lp, 4'd7, 16'h0a0a, 4'd3},
        '{1'b0, 2'd1, 2'd1, rd_lp, 4'd7, 16'h0000, 4'd3},
        '{1'b1, 2'd0, 2'd2, wr_lp, 4'd4, 16'hc3c3, 4'd3},
        '{1'b1, 2'd0, 2'd2, rd_lp, 4'd4, 16'h0000, 4'd3},
        '{1'b0, 2'd0, 2'd1, wr_lp, 4'd8, 16'h1111, 4'd4},
        '{1'b0, 2'd0, 2'd2, wr_lp, 4'd8, 16'h2222, 4'd4},
        '{1'b1, 2'd1, 2'd1, wr_lp, 4'd8, 16'h3333, 4'd4},
        '{1'b1, 2'd1, 2'd2, wr_lp, 4'd8, 16'h4444, 4'd4},
        '{1'b0, 2'd0, 2'd1, rd_lp, 4'd8, 16'h0000, 4'd4},
        '{1'b0, 2'd0, 2'd2, rd_lp, 4'd8, 16'h0000, 4'd4},
        '{1'b1, 2'd1, 2'd1, rd_lp, 4'd8, 16'h0000, 4'd4},
        '{1'b1, 2'd1, 2'd2, rd_lp, 4'd8, 16'h0000, 4'd4},
        '{1'b0, 2'd0, 2'd1, wr_lp, 4'd1, 16'h7777, 4'd5},
        '{1'b0, 2'd0, 2'd1, rd_lp, 4'd1, 16'h0000, 4'd5},
        '{1'b0, 2'd0, 2'd1, wr_lp, 4'd2, 16'h8888, 4'd5},
        '{1'b0, 2'd0, 2'd1, rd_lp, 4'd2, 16'h0000, 4'd5},
        '{1'b0, 2'd1, 2'd2, rd_lp, 4'd8, 16'h0000, 4'd5}};
      repeat (reset_cycles_lp) @(negedge core_clk);
      reset = 1'b0;
      check(32'(resp_v), 32'd0, "resp_v_o after reset");
      check(32'(cmd_ready_and), 32'({x_dim_lp{1'b1}}), "cmd_ready_and_o after reset");
      for (int t = 1; t <= 5; t++)
        begin
          queue_rows(t);
          if (t == 5)
            begin
              hold_resp[0] = 1'b1; // column 0 refuses responses until the mesh backs up
              for (int w = 0; w < 64 && stall_run[0] < 8; w++)
                cycle();
              check(32'(cmd_ready_and[0]), 32'd0, "cmd_ready_and_o[0] under back-pressure");
              check(32'(resp_v[0]), 32'd1, "resp_v_o[0] waiting under back-pressure");
              hold_resp[0] = 1'b0;
            end
          while (pending() > 0)
            cycle();
          finish_test(t);
        end
      for (int i = 0; i < rand_cmds_lp; i++)
        begin
          lcg_state = lcg_next(lcg_state);
          col = lcg_state[31];
          dx = noc_pkg::cord_t'(lcg_state[30]);
          dy = lcg_state[29] ? 2'd2 : 2'd1;
          op = lcg_state[28];
          addr = {lcg_state[27:25], col}; // columns own disjoint addresses, so order is fixed
          lcg_state = lcg_next(lcg_state);
          cmd_q[col].push_back(make_flit(col, dx, dy, op, addr, lcg_state[31:16]));
        end
      while (pending() > 0)
        cycle();
      finish_test(6);
      $display("summary: 6 tests, %0d commands, %0d responses, %0d errors",
               total_cmds, total_resps, errors);
      if (errors == 0 && total_resps == total_cmds)
        $display("ALL CHECKS PASSED");
      else
        $display("CHECKS FAILED");
      $finish;
    end

endmodule

/* sim.f */
rtl/noc_pkg.sv
rtl/mesh_router.sv
rtl/tile_mem_node.sv
rtl/core_complex.sv
tb/core_complex_chk.sv
tb/core_complex_tb.sv

/* run.sh */
#!/bin/sh
# build the core complex testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module core_complex_tb -f sim.f \
  -o core_complex_sim \
  && ./obj_dir/core_complex_sim | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
